/* dv/periph_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_bus_tb
	import periph_pkg::*;
	();

	localparam int CLK_PERIOD = 8;

	// cycle budgets per test
	localparam int T1_CYCLES = 100;
	localparam int T2_CYCLES = 1500;
	localparam int T3_CYCLES = 300;
	localparam int T4_CYCLES = 400;
	localparam int T5_CYCLES = 600;
	localparam int T6_CYCLES = 700;
	localparam int WATCHDOG_CYCLES =
		4 * (T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES + T6_CYCLES);

	localparam int BP_CREDIT_MAX = CMD_DEPTH + RSP_DEPTH + 3;

	// small video timing for the sync tests
	localparam int SYNC_HTOTAL = 20;
	localparam int SYNC_HEND   = 3;
	localparam int SYNC_VTOTAL = 6;
	localparam int SYNC_VEND   = 2;

	logic              peri_aclk;
	logic              peri_aresetn;
	logic              cmd_valid;
	bus_cmd_t          cmd;
	logic              cmd_credit;
	logic              rsp_credit;
	logic              rsp_valid;
	bus_rsp_t          rsp;
	logic [GPIO_W-1:0] sw;
	logic [GPIO_W-1:0] led;
	logic              hsync;
	logic              vsync;

	logic [31:0] lfsr_state;
	bus_cmd_t    send_q[$];
	bus_rsp_t    exp_q[$];
	int          cmd_credits;
	int          cmds_sent;
	int          credit_pulses;
	int          rsp_given;
	int          rsp_seen;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          cycle_cnt;
	logic        grant;
	logic        rand_credit;
	logic        hs_now;
	logic        vs_now;

	// register model
	logic [GPIO_W-1:0]   m_led;
	logic [2:0]          m_ctl;
	logic [TIMING_W-1:0] m_htotal;
	logic [TIMING_W-1:0] m_hsend;
	logic [TIMING_W-1:0] m_vtotal;
	logic [TIMING_W-1:0] m_vsend;

	tb_clock_gen #(
		.PERIOD_NS    (CLK_PERIOD),
		.RESET_CYCLES (3)
	) tb_clock_gen_inst (
		.clk_o  (peri_aclk),
		.rstn_o (peri_aresetn)
	);

	periph_bus_top periph_bus_top_inst (
		.peri_aclk    (peri_aclk),
		.peri_aresetn (peri_aresetn),
		.cmd_valid_i  (cmd_valid),
		.cmd_i        (cmd),
		.cmd_credit_o (cmd_credit),
		.rsp_credit_i (rsp_credit),
		.rsp_valid_o  (rsp_valid),
		.rsp_o        (rsp),
		.sw_i         (sw),
		.led_o        (led),
		.hsync_o      (hsync),
		.vsync_o      (vsync)
	);

	// --------------------
	// random source
	// --------------------
	// galois lfsr, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        lsb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lsb        = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb) begin
				lfsr_state = lfsr_state ^ 32'h8020_0003;
			end
			val = {val[30:0], lsb};
		end
		return val;
	endfunction

	function automatic logic [ADDR_W-1:0] reg_addr(input logic [19:0] page,
	                                               input logic [3:0] idx);
		return {page, 6'd0, idx, 2'd0};
	endfunction

	function automatic logic [ADDR_W-1:0] rand_addr();
		logic [1:0]        kind;
		logic [ADDR_W-1:0] addr;
		kind = 2'(rand_bits(2));
		addr = rand_bits(32);
		// gpio, sync twice as often, or anywhere
		case (kind)
			2'd0:    addr[31:12] = PAGE_GPIO;
			2'd1:    addr[31:12] = PAGE_SYNC;
			2'd2:    addr[31:12] = PAGE_SYNC;
			default: addr = addr;
		endcase
		// indices 0 to 7, every register and some holes
		addr[5] = 1'b0;
		return addr;
	endfunction

	// --------------------
	// register model
	// --------------------
	function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
		logic [19:0] page;
		logic [3:0]  idx;
		page = addr[31:12];
		idx  = addr[5:2];
		if (page == PAGE_GPIO) begin
			if (idx == IDX_GPIO_OUT) begin
				return 32'(m_led);
			end
			if (idx == IDX_GPIO_IN) begin
				return 32'(sw);
			end
		end else if (page == PAGE_SYNC) begin
			case (idx)
				IDX_SYNC_CTL:       return 32'(m_ctl);
				IDX_SYNC_HTOTAL:    return 32'(m_htotal);
				IDX_SYNC_HSYNC_END: return 32'(m_hsend);
				IDX_SYNC_VTOTAL:    return 32'(m_vtotal);
				IDX_SYNC_VSYNC_END: return 32'(m_vsend);
				default:            return '0;
			endcase
		end
		return '0;
	endfunction

	function automatic void model_write(input logic [ADDR_W-1:0] addr,
	                                    input logic [DATA_W-1:0] wdata,
	                                    input logic [SEL_W-1:0]  sel);
		logic [DATA_W-1:0] mask;
		logic [DATA_W-1:0] val;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		val  = (model_read(addr) & ~mask) | (wdata & mask);
		if (addr[31:12] == PAGE_GPIO && addr[5:2] == IDX_GPIO_OUT) begin
			m_led = val[GPIO_W-1:0];
		end
		if (addr[31:12] == PAGE_SYNC) begin
			case (addr[5:2])
				IDX_SYNC_CTL:       m_ctl    = val[2:0];
				IDX_SYNC_HTOTAL:    m_htotal = val[TIMING_W-1:0];
				IDX_SYNC_HSYNC_END: m_hsend  = val[TIMING_W-1:0];
				IDX_SYNC_VTOTAL:    m_vtotal = val[TIMING_W-1:0];
				IDX_SYNC_VSYNC_END: m_vsend  = val[TIMING_W-1:0];
				default:            m_ctl    = m_ctl;
			endcase
		end
	endfunction

	task automatic host_cmd(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
	                        input logic [SEL_W-1:0] sel, input logic we);
		bus_cmd_t c;
		bus_rsp_t r;
		c.addr  = addr;
		c.wdata = wdata;
		c.sel   = sel;
		c.we    = we;
		r.we    = we;
		r.rdata = we ? '0 : model_read(addr);
		if (we) begin
			model_write(addr, wdata, sel);
		end
		send_q.push_back(c);
		exp_q.push_back(r);
	endtask

	// --------------------
	// host, one clock per call
	// --------------------
	task automatic cycle();
		bus_rsp_t want;
		logic     give;
		@(negedge peri_aclk);
		cycle_cnt++;
		hs_now = hsync;
		vs_now = vsync;
		if (cmd_credit) begin
			cmd_credits++;
			credit_pulses++;
			if (credit_pulses > cmds_sent) begin
				$display("cmd_credit_o pulsed %0d times for only %0d commands at %0t",
					credit_pulses, cmds_sent, $time);
				errors++;
			end
		end
		if (rsp_valid) begin
			rsp_seen++;
			if (rsp_seen > rsp_given) begin
				$display("rsp_valid_o pulsed %0d times with only %0d credits at %0t",
					rsp_seen, rsp_given, $time);
				errors++;
			end
			if (exp_q.size() == 0) begin
				$display("response arrived with no command outstanding at %0t", $time);
				errors++;
			end else begin
				want = exp_q.pop_front();
				if (rsp !== want) begin
					$display("** Error at %0t: rsp_o expected %h got %h", $time, want, rsp);
					errors++;
				end
			end
		end
		cmd_valid = 1'b0;
		if (send_q.size() != 0 && cmd_credits > 0) begin
			cmd       = send_q.pop_front();
			cmd_valid = 1'b1;
			cmd_credits--;
			cmds_sent++;
		end
		// never pay for more responses than are owed
		give = 1'b0;
		if (grant && (rsp_given - rsp_seen) < exp_q.size()) begin
			give = rand_credit ? (rand_bits(1) != 0) : 1'b1;
		end
		rsp_credit = give;
		if (give) begin
			rsp_given++;
		end
	endtask

	task automatic drain(input int limit);
		int n;
		n = 0;
		while ((send_q.size() != 0 || exp_q.size() != 0) && n < limit) begin
			cycle();
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d responses still missing after %0d cycles", exp_q.size(), limit);
			errors++;
			send_q.delete();
			exp_q.delete();
		end
	endtask

	task automatic check_sync(input logic act, input int cycles);
		int   h_last;
		int   v_last;
		int   h_starts;
		int   v_starts;
		logic h_prev;
		logic v_prev;
		h_last   = -1;
		v_last   = -1;
		h_starts = 0;
		v_starts = 0;
		h_prev   = hs_now;
		v_prev   = vs_now;
		repeat (cycles) begin
			cycle();
			if (hs_now == act && h_prev != act) begin
				if (h_last >= 0 && cycle_cnt - h_last != SYNC_HTOTAL) begin
					$display("** Error at %0t: hsync_o period expected %0d got %0d",
						$time, SYNC_HTOTAL, cycle_cnt - h_last);
					errors++;
				end
				h_last = cycle_cnt;
				h_starts++;
			end else if (hs_now != act && h_prev == act && h_last >= 0) begin
				if (cycle_cnt - h_last != SYNC_HEND) begin
					$display("** Error at %0t: hsync_o width expected %0d got %0d",
						$time, SYNC_HEND, cycle_cnt - h_last);
					errors++;
				end
			end
			if (vs_now == act && v_prev != act) begin
				if (v_last >= 0 && cycle_cnt - v_last != SYNC_HTOTAL * SYNC_VTOTAL) begin
					$display("** Error at %0t: vsync_o period expected %0d got %0d",
						$time, SYNC_HTOTAL * SYNC_VTOTAL, cycle_cnt - v_last);
					errors++;
				end
				v_last = cycle_cnt;
				v_starts++;
			end else if (vs_now != act && v_prev == act && v_last >= 0) begin
				if (cycle_cnt - v_last != SYNC_HTOTAL * SYNC_VEND) begin
					$display("** Error at %0t: vsync_o width expected %0d got %0d",
						$time, SYNC_HTOTAL * SYNC_VEND, cycle_cnt - v_last);
					errors++;
				end
			end
			h_prev = hs_now;
			v_prev = vs_now;
		end
		if (h_starts < 3 || v_starts < 2) begin
			$display("too few sync pulses: %0d hsync, %0d vsync", h_starts, v_starts);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		tests_run++;
		if (errors == errs_at_start) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: FAILED with %0d errors", name, errors - errs_at_start);
		end
	endtask

	// --------------------
	// watchdog
	// --------------------
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		int   start;
		int   pulses_at;
		int   pulses_mid;
		int   seen_at;
		logic idle_bad;
		lfsr_state    = 32'd81;
		cmd_credits   = CMD_DEPTH;
		cmds_sent     = 0;
		credit_pulses = 0;
		rsp_given     = 0;
		rsp_seen      = 0;
		errors        = 0;
		tests_run     = 0;
		tests_failed  = 0;
		cycle_cnt     = 0;
		grant         = 1'b0;
		rand_credit   = 1'b0;
		m_led         = GPIO_OUT_RESET;
		m_ctl         = SYNC_CTL_RESET;
		m_htotal      = HTOTAL_RESET;
		m_hsend       = HSYNC_END_RESET;
		m_vtotal      = VTOTAL_RESET;
		m_vsend       = VSYNC_END_RESET;
		cmd_valid     = 1'b0;
		cmd           = '0;
		rsp_credit    = 1'b0;
		sw            = GPIO_W'(rand_bits(GPIO_W));

		// reset values, checked while reset is still held
		start = errors;
		@(posedge peri_aclk);
		@(negedge peri_aclk);
		if (led !== GPIO_OUT_RESET) begin
			$display("** Error at %0t: led_o expected %h got %h", $time, GPIO_OUT_RESET, led);
			errors++;
		end
		if (hsync !== 1'b1 || vsync !== 1'b1) begin
			$display("** Error at %0t: hsync_o/vsync_o expected 11 got %b%b",
				$time, hsync, vsync);
			errors++;
		end
		if (cmd_credit !== 1'b0 || rsp_valid !== 1'b0) begin
			$display("** Error at %0t: cmd_credit_o/rsp_valid_o expected 00 got %b%b",
				$time, cmd_credit, rsp_valid);
			errors++;
		end
		wait (peri_aresetn);
		grant = 1'b1;
		for (int i = 0; i < 5; i++) begin
			host_cmd(reg_addr(PAGE_SYNC, 4'(i)), '0, 4'hF, 1'b0);
		end
		host_cmd(reg_addr(PAGE_GPIO, IDX_GPIO_OUT), '0, 4'hF, 1'b0);
		host_cmd(reg_addr(PAGE_GPIO, IDX_GPIO_IN), '0, 4'hF, 1'b0);
		drain(T1_CYCLES);
		finish_test("test 1 reset values", start);

		// random traffic
		start       = errors;
		rand_credit = 1'b1;
		for (int i = 0; i < 200; i++) begin
			host_cmd(rand_addr(), rand_bits(32), SEL_W'(rand_bits(SEL_W)), rand_bits(1) != 0);
		end
		drain(T2_CYCLES);
		if (led !== m_led) begin
			$display("** Error at %0t: led_o expected %h got %h", $time, m_led, led);
			errors++;
		end
		finish_test("test 2 random access", start);

		// back-pressure with no response credits
		start       = errors;
		grant       = 1'b0;
		rand_credit = 1'b0;
		pulses_at   = credit_pulses;
		seen_at     = rsp_seen;
		for (int i = 0; i < 16; i++) begin
			host_cmd(rand_addr(), '0, 4'hF, 1'b0);
		end
		repeat (60) cycle();
		pulses_mid = credit_pulses;
		repeat (20) cycle();
		if (credit_pulses - pulses_at > BP_CREDIT_MAX) begin
			$display("** Error at %0t: cmd_credit_o pulses expected at most %0d got %0d",
				$time, BP_CREDIT_MAX, credit_pulses - pulses_at);
			errors++;
		end
		if (credit_pulses != pulses_mid) begin
			$display("command credits kept flowing with no response credits");
			errors++;
		end
		if (rsp_seen != seen_at) begin
			$display("responses appeared while no response credit was granted");
			errors++;
		end
		grant = 1'b1;
		drain(T3_CYCLES);
		finish_test("test 3 back-pressure", start);

		// credit rule over a random burst
		start       = errors;
		rand_credit = 1'b1;
		for (int i = 0; i < 40; i++) begin
			host_cmd(rand_addr(), rand_bits(32), SEL_W'(rand_bits(SEL_W)), rand_bits(1) != 0);
		end
		drain(T4_CYCLES);
		if (rsp_seen > rsp_given || credit_pulses > cmds_sent) begin
			$display("credit totals broken: %0d responses for %0d credits, %0d for %0d commands",
				rsp_seen, rsp_given, credit_pulses, cmds_sent);
			errors++;
		end
		finish_test("test 4 credit rule", start);

		// sync timing, active low
		start       = errors;
		rand_credit = 1'b0;
		host_cmd(reg_addr(PAGE_SYNC, IDX_SYNC_CTL), 32'd0, 4'hF, 1'b1);
		host_cmd(reg_addr(PAGE_SYNC, IDX_SYNC_HTOTAL), SYNC_HTOTAL, 4'hF, 1'b1);
		host_cmd(reg_addr(PAGE_SYNC, IDX_SYNC_HSYNC_END), SYNC_HEND, 4'hF, 1'b1);
		host_cmd(reg_addr(PAGE_SYNC, IDX_SYNC_VTOTAL), SYNC_VTOTAL, 4'hF, 1'b1);
		host_cmd(reg_addr(PAGE_SYNC, IDX_SYNC_VSYNC_END), SYNC_VEND, 4'hF, 1'b1);
		host_cmd(reg_addr(PAGE_SYNC, IDX_SYNC_CTL), 32'd1, 4'hF, 1'b1);
		drain(T1_CYCLES);
		check_sync(1'b0, 400);
		finish_test("test 5 sync timing", start);

		// inverted polarity, then disabled
		start = errors;
		host_cmd(reg_addr(PAGE_SYNC, IDX_SYNC_CTL), 32'd7, 4'hF, 1'b1);
		drain(T1_CYCLES);
		check_sync(1'b1, 400);
		host_cmd(reg_addr(PAGE_SYNC, IDX_SYNC_CTL), 32'd6, 4'hF, 1'b1);
		drain(T1_CYCLES);
		repeat (2) cycle();
		idle_bad = 1'b0;
		repeat (100) begin
			cycle();
			if ((hs_now !== 1'b0 || vs_now !== 1'b0) && !idle_bad) begin
				$display("** Error at %0t: hsync_o/vsync_o expected 00 got %b%b",
					$time, hs_now, vs_now);
				errors++;
				idle_bad = 1'b1;
			end
		end
		finish_test("test 6 polarity and disable", start);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_o,
	output logic rstn_o
);

	always #(PERIOD_NS / 2) clk_o = ~clk_o;

	// release on a falling edge, away from the sampling edge
	initial begin
		clk_o  = 1'b0;
		rstn_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rstn_o = 1'b1;
	end

endmodule

`default_nettype wire

/* flist.f */
hw/periph_pkg.sv
hw/credit_fifo.sv
hw/bus_decode.sv
hw/bus_execute.sv
hw/sync_timing_gen.sv
hw/bus_result.sv
hw/periph_bus_top.sv
dv/tb_clock_gen.sv
dv/periph_bus_tb.sv

/* hw/bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decode
	import periph_pkg::*;
	(
		input  wire           peri_aclk,
		input  wire           peri_aresetn,
		input  wire           cmd_empty_i,
		input  wire bus_cmd_t cmd_i,
		input  wire           room_i,
		output logic          pop_o,
		output logic          dec_valid_o,
		output bus_dec_t      dec_o
	);

	logic [ADDR_W-PAGE_LSB-1:0] page;
	region_e                    region;

	// pop only with a response slot reserved downstream
	assign pop_o = !cmd_empty_i && room_i;
	assign page  = cmd_i.addr[ADDR_W-1:PAGE_LSB];

	// --------------------
	// address map
	// --------------------
	always_comb begin
		if (page == PAGE_GPIO) begin
			region = REGION_GPIO;
		end else if (page == PAGE_SYNC) begin
			region = REGION_SYNC;
		end else begin
			// default ack, reads zero
			region = REGION_NONE;
		end
	end

	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			dec_valid_o <= 1'b0;
		end else begin
			dec_valid_o <= pop_o;
		end
	end

	always_ff @(posedge peri_aclk) begin
		if (pop_o) begin
			dec_o.region <= region;
			dec_o.idx    <= cmd_i.addr[IDX_LSB +: REG_IDX_W];
			dec_o.wdata  <= cmd_i.wdata;
			dec_o.sel    <= cmd_i.sel;
			dec_o.we     <= cmd_i.we;
		end
	end

endmodule

`default_nettype wire

/* hw/bus_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_execute
	import periph_pkg::*;
	(
		input  wire                peri_aclk,
		input  wire                peri_aresetn,
		input  wire                dec_valid_i,
		input  wire bus_dec_t      dec_i,
		input  wire [GPIO_W-1:0]   sw_i,
		output logic [GPIO_W-1:0]  led_o,
		output sync_cfg_t          sync_cfg_o,
		output logic               rsp_valid_o,
		output bus_rsp_t           rsp_o
	);

	logic [GPIO_W-1:0] led_q;
	sync_cfg_t         cfg_q;
	logic [DATA_W-1:0] cur_data;
	logic [DATA_W-1:0] wr_data;
	logic              wr_en;

	function automatic logic [DATA_W-1:0] merge_bytes(
		input logic [DATA_W-1:0] old_data,
		input logic [DATA_W-1:0] new_data,
		input logic [SEL_W-1:0]  sel
	);
		logic [DATA_W-1:0] result;
		result = old_data;
		for (int i = 0; i < SEL_W; i++) begin
			if (sel[i]) begin
				result[8*i +: 8] = new_data[8*i +: 8];
			end
		end
		return result;
	endfunction

	// --------------------
	// read mux
	// --------------------
	always_comb begin
		cur_data = '0;
		case (dec_i.region)
			REGION_GPIO: begin
				case (dec_i.idx)
					IDX_GPIO_OUT: cur_data = DATA_W'(led_q);
					IDX_GPIO_IN:  cur_data = DATA_W'(sw_i);
					default:      cur_data = '0;
				endcase
			end
			REGION_SYNC: begin
				case (dec_i.idx)
					IDX_SYNC_CTL:
						cur_data = DATA_W'({cfg_q.vsync_pol, cfg_q.hsync_pol, cfg_q.enable});
					IDX_SYNC_HTOTAL:    cur_data = DATA_W'(cfg_q.htotal);
					IDX_SYNC_HSYNC_END: cur_data = DATA_W'(cfg_q.hsync_end);
					IDX_SYNC_VTOTAL:    cur_data = DATA_W'(cfg_q.vtotal);
					IDX_SYNC_VSYNC_END: cur_data = DATA_W'(cfg_q.vsync_end);
					default:            cur_data = '0;
				endcase
			end
			default: cur_data = '0;
		endcase
	end

	assign wr_data = merge_bytes(cur_data, dec_i.wdata, dec_i.sel);
	assign wr_en   = dec_valid_i && dec_i.we;

	// --------------------
	// register file
	// --------------------
	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			led_q           <= GPIO_OUT_RESET;
			cfg_q.enable    <= SYNC_CTL_RESET[0];
			cfg_q.hsync_pol <= SYNC_CTL_RESET[1];
			cfg_q.vsync_pol <= SYNC_CTL_RESET[2];
			cfg_q.htotal    <= HTOTAL_RESET;
			cfg_q.hsync_end <= HSYNC_END_RESET;
			cfg_q.vtotal    <= VTOTAL_RESET;
			cfg_q.vsync_end <= VSYNC_END_RESET;
		end else if (wr_en) begin
			if (dec_i.region == REGION_GPIO && dec_i.idx == IDX_GPIO_OUT) begin
				led_q <= wr_data[GPIO_W-1:0];
			end
			if (dec_i.region == REGION_SYNC) begin
				case (dec_i.idx)
					IDX_SYNC_CTL: begin
						cfg_q.enable    <= wr_data[0];
						cfg_q.hsync_pol <= wr_data[1];
						cfg_q.vsync_pol <= wr_data[2];
					end
					IDX_SYNC_HTOTAL:    cfg_q.htotal    <= wr_data[TIMING_W-1:0];
					IDX_SYNC_HSYNC_END: cfg_q.hsync_end <= wr_data[TIMING_W-1:0];
					IDX_SYNC_VTOTAL:    cfg_q.vtotal    <= wr_data[TIMING_W-1:0];
					IDX_SYNC_VSYNC_END: cfg_q.vsync_end <= wr_data[TIMING_W-1:0];
					default:            cfg_q <= cfg_q;
				endcase
			end
		end
	end

	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= dec_valid_i;
		end
	end

	// writes answer with zero data
	always_ff @(posedge peri_aclk) begin
		if (dec_valid_i) begin
			rsp_o.rdata <= dec_i.we ? '0 : cur_data;
			rsp_o.we    <= dec_i.we;
		end
	end

	assign led_o      = led_q;
	assign sync_cfg_o = cfg_q;

endmodule

`default_nettype wire

/* hw/bus_result.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_result
	import periph_pkg::*;
	(
		input  wire           peri_aclk,
		input  wire           peri_aresetn,
		input  wire           issue_i,
		output logic          room_o,
		input  wire           rsp_valid_i,
		input  wire bus_rsp_t rsp_i,
		input  wire           rsp_credit_i,
		output logic          rsp_valid_o,
		output bus_rsp_t      rsp_o
	);

	localparam int SLOT_W = $clog2(RSP_DEPTH + 1);

	logic [SLOT_W-1:0]   reserved;
	logic [SLOT_W-1:0]   rsp_free;
	logic [CREDIT_W-1:0] credits;
	logic                rsp_empty;
	logic                send;

	credit_fifo #(
		.payload_t (bus_rsp_t),
		.DEPTH     (RSP_DEPTH)
	) rsp_fifo_inst (
		.peri_aclk    (peri_aclk),
		.peri_aresetn (peri_aresetn),
		.push_i       (rsp_valid_i),
		.push_data_i  (rsp_i),
		.pop_i        (send),
		.pop_data_o   (rsp_o),
		.empty_o      (rsp_empty),
		.free_o       (rsp_free)
	);

	// slots still open after counting everything in flight
	assign room_o      = rsp_free > reserved;
	assign send        = !rsp_empty && (credits != '0);
	assign rsp_valid_o = send;

	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			reserved <= '0;
			credits  <= '0;
		end else begin
			case ({issue_i, rsp_valid_i})
				2'b10:   reserved <= reserved + 1'b1;
				2'b01:   reserved <= reserved - 1'b1;
				default: reserved <= reserved;
			endcase
			case ({rsp_credit_i, send})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/credit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_fifo
	import periph_pkg::*;
	#(
		parameter type payload_t = bus_cmd_t,
		parameter int  DEPTH     = CMD_DEPTH
	)
	(
		input  wire                          peri_aclk,
		input  wire                          peri_aresetn,
		input  wire                          push_i,
		input  wire  payload_t               push_data_i,
		input  wire                          pop_i,
		output payload_t                     pop_data_o,
		output logic                         empty_o,
		output logic [$clog2(DEPTH+1)-1:0]   free_o
	);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// pointer step with wrap for any depth
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// no full check, the sender only pushes with a credit
	always_ff @(posedge peri_aclk) begin
		if (push_i) begin
			mem[wr_ptr] <= push_data_i;
		end
	end

	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop_i) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({push_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign pop_data_o = mem[rd_ptr];
	assign empty_o    = (count == '0);
	assign free_o     = CNT_W'(DEPTH) - count;

endmodule

`default_nettype wire

/* hw/periph_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_bus_top
	import periph_pkg::*;
	(
		input  wire              peri_aclk,
		input  wire              peri_aresetn,
		input  wire              cmd_valid_i,
		input  wire bus_cmd_t    cmd_i,
		output wire              cmd_credit_o,
		input  wire              rsp_credit_i,
		output wire              rsp_valid_o,
		output wire bus_rsp_t    rsp_o,
		input  wire [GPIO_W-1:0] sw_i,
		output wire [GPIO_W-1:0] led_o,
		output wire              hsync_o,
		output wire              vsync_o
	);

	bus_cmd_t  cmd_head;
	logic      cmd_empty;
	logic      cmd_pop;
	logic      room;
	logic      dec_valid;
	bus_dec_t  dec;
	logic      exe_valid;
	bus_rsp_t  exe_rsp;
	sync_cfg_t sync_cfg;

	// a pop frees one command slot at the host
	assign cmd_credit_o = cmd_pop;

	// --------------------
	// command path
	// --------------------
	credit_fifo #(
		.payload_t (bus_cmd_t),
		.DEPTH     (CMD_DEPTH)
	) cmd_fifo_inst (
		.peri_aclk    (peri_aclk),
		.peri_aresetn (peri_aresetn),
		.push_i       (cmd_valid_i),
		.push_data_i  (cmd_i),
		.pop_i        (cmd_pop),
		.pop_data_o   (cmd_head),
		.empty_o      (cmd_empty),
		.free_o       ()
	);

	bus_decode bus_decode_inst (
		.peri_aclk    (peri_aclk),
		.peri_aresetn (peri_aresetn),
		.cmd_empty_i  (cmd_empty),
		.cmd_i        (cmd_head),
		.room_i       (room),
		.pop_o        (cmd_pop),
		.dec_valid_o  (dec_valid),
		.dec_o        (dec)
	);

	bus_execute bus_execute_inst (
		.peri_aclk    (peri_aclk),
		.peri_aresetn (peri_aresetn),
		.dec_valid_i  (dec_valid),
		.dec_i        (dec),
		.sw_i         (sw_i),
		.led_o        (led_o),
		.sync_cfg_o   (sync_cfg),
		.rsp_valid_o  (exe_valid),
		.rsp_o        (exe_rsp)
	);

	bus_result bus_result_inst (
		.peri_aclk    (peri_aclk),
		.peri_aresetn (peri_aresetn),
		.issue_i      (cmd_pop),
		.room_o       (room),
		.rsp_valid_i  (exe_valid),
		.rsp_i        (exe_rsp),
		.rsp_credit_i (rsp_credit_i),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_o        (rsp_o)
	);

	// --------------------
	// video sync
	// --------------------
	sync_timing_gen sync_timing_gen_inst (
		.peri_aclk    (peri_aclk),
		.peri_aresetn (peri_aresetn),
		.cfg_i        (sync_cfg),
		.hsync_o      (hsync_o),
		.vsync_o      (vsync_o)
	);

endmodule

`default_nettype wire

/* hw/periph_pkg.sv */
`default_nettype none

package periph_pkg;

	// --------------------
	// host bus
	// --------------------
	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 32;
	localparam int SEL_W     = 4;
	localparam int PAGE_LSB  = 12;
	localparam int IDX_LSB   = 2;
	localparam int REG_IDX_W = 4;
	localparam int CREDIT_W  = 8;

	localparam logic [ADDR_W-PAGE_LSB-1:0] PAGE_GPIO = 20'h4002_1;
	localparam logic [ADDR_W-PAGE_LSB-1:0] PAGE_SYNC = 20'h4001_1;

	// queue depths, also the starting credits
	localparam int CMD_DEPTH = 4;
	localparam int RSP_DEPTH = 4;

	// --------------------
	// gpio
	// --------------------
	localparam int GPIO_W = 4;
	localparam logic [GPIO_W-1:0] GPIO_OUT_RESET = 4'b0101;

	localparam logic [REG_IDX_W-1:0] IDX_GPIO_OUT = 4'd0;
	localparam logic [REG_IDX_W-1:0] IDX_GPIO_IN  = 4'd1;

	// --------------------
	// sync generator
	// --------------------
	localparam int TIMING_W = 12;

	localparam logic [REG_IDX_W-1:0] IDX_SYNC_CTL       = 4'd0;
	localparam logic [REG_IDX_W-1:0] IDX_SYNC_HTOTAL    = 4'd1;
	localparam logic [REG_IDX_W-1:0] IDX_SYNC_HSYNC_END = 4'd2;
	localparam logic [REG_IDX_W-1:0] IDX_SYNC_VTOTAL    = 4'd3;
	localparam logic [REG_IDX_W-1:0] IDX_SYNC_VSYNC_END = 4'd4;

	// ctl bit 0 enable, bit 1 hsync pol, bit 2 vsync pol (0 = active low)
	localparam logic [2:0] SYNC_CTL_RESET = 3'b001;

	localparam logic [TIMING_W-1:0] HTOTAL_RESET    = 12'd800;
	localparam logic [TIMING_W-1:0] HSYNC_END_RESET = 12'd96;
	localparam logic [TIMING_W-1:0] VTOTAL_RESET    = 12'd525;
	localparam logic [TIMING_W-1:0] VSYNC_END_RESET = 12'd2;

	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_GPIO,
		REGION_SYNC
	} region_e;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [SEL_W-1:0]  sel;
		logic              we;
	} bus_cmd_t;

	typedef struct packed {
		region_e              region;
		logic [REG_IDX_W-1:0] idx;
		logic [DATA_W-1:0]    wdata;
		logic [SEL_W-1:0]     sel;
		logic                 we;
	} bus_dec_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic              we;
	} bus_rsp_t;

	typedef struct packed {
		logic                enable;
		logic                hsync_pol;
		logic                vsync_pol;
		logic [TIMING_W-1:0] htotal;
		logic [TIMING_W-1:0] hsync_end;
		logic [TIMING_W-1:0] vtotal;
		logic [TIMING_W-1:0] vsync_end;
	} sync_cfg_t;

endpackage

`default_nettype wire

/* hw/sync_timing_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_timing_gen
	import periph_pkg::*;
	(
		input  wire            peri_aclk,
		input  wire            peri_aresetn,
		input  wire sync_cfg_t cfg_i,
		output logic           hsync_o,
		output logic           vsync_o
	);

	logic [TIMING_W-1:0] h_cnt;
	logic [TIMING_W-1:0] v_cnt;
	logic [TIMING_W:0]   h_next;
	logic [TIMING_W:0]   v_next;
	logic                h_wrap;
	logic                v_wrap;

	// one extra bit so a total of 4095 still wraps
	assign h_next = {1'b0, h_cnt} + 1'b1;
	assign v_next = {1'b0, v_cnt} + 1'b1;
	assign h_wrap = h_next >= {1'b0, cfg_i.htotal};
	assign v_wrap = v_next >= {1'b0, cfg_i.vtotal};

	always_ff @(posedge peri_aclk) begin
		if (!peri_aresetn) begin
			h_cnt   <= '0;
			v_cnt   <= '0;
			hsync_o <= 1'b1;
			vsync_o <= 1'b1;
		end else if (!cfg_i.enable) begin
			// parked, outputs at their inactive level
			h_cnt   <= '0;
			v_cnt   <= '0;
			hsync_o <= !cfg_i.hsync_pol;
			vsync_o <= !cfg_i.vsync_pol;
		end else begin
			h_cnt <= h_wrap ? '0 : h_next[TIMING_W-1:0];
			if (h_wrap) begin
				v_cnt <= v_wrap ? '0 : v_next[TIMING_W-1:0];
			end
			// pol 1 means active high
			hsync_o <= (h_cnt < cfg_i.hsync_end) ? cfg_i.hsync_pol : !cfg_i.hsync_pol;
			vsync_o <= (v_cnt < cfg_i.vsync_end) ? cfg_i.vsync_pol : !cfg_i.vsync_pol;
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module periph_bus_tb -f flist.f \
	&& ./obj_dir/Vperiph_bus_tb | tee /dev/stderr | grep -qx "Testbench passed" \
	&& { echo "simulation ok"; exit 0; } \
	|| { echo "simulation not ok"; exit 1; }
